/* eth_proto_pkg.sv */
`default_nettype none

package eth_proto_pkg;

    // every packet opens with these two bytes
    localparam logic [7:0] SYNC_BYTE0 = 8'hEF;
    localparam logic [7:0] SYNC_BYTE1 = 8'hFE;

    // command codes in byte 2
    localparam logic [7:0] CMD_DATA     = 8'h01;
    localparam logic [7:0] CMD_DISCOVER = 8'h02;
    localparam logic [7:0] CMD_RUN      = 8'h04;

    // endpoint codes in byte 3 of data packets
    localparam logic [7:0] EP_RX_AUDIO = 8'h02;
    localparam logic [7:0] EP_TX_IQ    = 8'h06;
    localparam logic [7:0] EP_SPECTRUM = 8'h04;

    localparam logic [15:0] CMD_PORT = 16'd1024;

    // packet sizes in bytes
    localparam logic [10:0] PAYLOAD_BYTES = 11'd32;
    localparam logic [10:0] HDR_BYTES     = 11'd8;
    localparam logic [10:0] FRAME_BYTES   = HDR_BYTES + PAYLOAD_BYTES;
    localparam logic [10:0] DISC_BYTES    = 11'd60;

    // header field offsets
    localparam logic [10:0] OFS_CMD = 11'd2;
    localparam logic [10:0] OFS_EP  = 11'd3;
    localparam logic [10:0] OFS_SEQ = 11'd4;

    // discovery reply layout
    localparam logic [7:0]  DISC_REPLY_RUN = 8'h03;
    localparam logic [10:0] DISC_MAC_OFS   = 11'd3;
    localparam logic [10:0] DISC_VER_OFS   = 11'd9;
    localparam logic [10:0] DISC_ID_OFS    = 11'd10;
    localparam logic [10:0] DISC_NR_OFS    = 11'd11;
    localparam logic [7:0]  CODE_VERSION   = 8'h48;
    localparam logic [7:0]  BOARD_ID_A     = 8'h06;
    localparam logic [7:0]  BOARD_ID_B     = 8'h01;

    // one full payload waiting starts an iq frame
    localparam logic [10:0] IQ_THRESHOLD = PAYLOAD_BYTES;

endpackage

`default_nettype wire

/* eth_link_pkg.sv */
`default_nettype none

package eth_link_pkg;

    // one byte from the udp receive side
    typedef struct packed {
        logic        active;
        logic [7:0]  data;
        logic [15:0] to_port;
        logic        broadcast;
    } udp_rx_t;

    // udp transmit stream towards the network stack
    // request and length hold until the grant pulse
    typedef struct packed {
        logic        request;
        logic [10:0] length;
        logic        active;
        logic [7:0]  data;
    } udp_tx_t;

    // run controls from the host
    typedef struct packed {
        logic run;
        logic wide_spectrum;
    } run_ctrl_t;

endpackage

`default_nettype wire

/* cdc_sync.sv */
`timescale 1ns/1ps
`default_nettype none

module cdc_sync #(
    parameter type sync_t = logic
) (
    input  logic  clock,
    input  logic  arst_n_i,
    input  sync_t d_i,
    output sync_t q_o
);

    // first stage may go metastable
    sync_t meta_q;

    always_ff @(posedge clock or negedge arst_n_i) begin
        if (!arst_n_i) begin
            meta_q <= '0;
            q_o    <= '0;
        end else begin
            meta_q <= d_i;
            q_o    <= meta_q;
        end
    end

endmodule

`default_nettype wire

/* rx_command_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module rx_command_decoder
    import eth_proto_pkg::*, eth_link_pkg::*;
(
    input  logic       rx_clock,
    input  logic       arst_n_i,
    input  udp_rx_t    udp_rx_i,
    output run_ctrl_t  ctrl_o,
    output logic       disc_toggle_o,
    output logic       rx_fifo_wr_o,
    output logic [7:0] rx_fifo_data_o
);

    logic        active_q;
    logic [10:0] byte_cnt_q;
    logic [10:0] byte_idx;
    logic        start;
    logic        pkt_ok_q;
    logic [7:0]  cmd_q;
    logic        audio_q;

    // first beat of a packet restarts the count
    assign start    = udp_rx_i.active && !active_q;
    assign byte_idx = start ? 11'd0 : byte_cnt_q;

    always_ff @(posedge rx_clock or negedge arst_n_i) begin
        if (!arst_n_i) begin
            active_q      <= 1'b0;
            byte_cnt_q    <= '0;
            pkt_ok_q      <= 1'b0;
            cmd_q         <= '0;
            audio_q       <= 1'b0;
            ctrl_o        <= '0;
            disc_toggle_o <= 1'b0;
            rx_fifo_wr_o  <= 1'b0;
        end else begin
            active_q     <= udp_rx_i.active;
            rx_fifo_wr_o <= 1'b0;
            if (udp_rx_i.active) begin
                // saturate on oversized packets
                if (byte_idx != '1) begin
                    byte_cnt_q <= byte_idx + 11'd1;
                end
                if (byte_idx == 11'd0) begin
                    pkt_ok_q <= (udp_rx_i.data == SYNC_BYTE0) &&
                                (udp_rx_i.to_port == CMD_PORT);
                    audio_q  <= 1'b0;
                end else if (byte_idx == 11'd1) begin
                    pkt_ok_q <= pkt_ok_q && (udp_rx_i.data == SYNC_BYTE1);
                end else if (pkt_ok_q) begin
                    if (byte_idx == OFS_CMD) begin
                        cmd_q <= udp_rx_i.data;
                        // discovery only counts when broadcast
                        if (udp_rx_i.data == CMD_DISCOVER && udp_rx_i.broadcast) begin
                            disc_toggle_o <= !disc_toggle_o;
                        end
                    end else if (byte_idx == OFS_EP) begin
                        if (cmd_q == CMD_RUN) begin
                            ctrl_o.run           <= udp_rx_i.data[0];
                            ctrl_o.wide_spectrum <= udp_rx_i.data[1];
                        end
                        audio_q <= (cmd_q == CMD_DATA) && (udp_rx_i.data == EP_RX_AUDIO);
                    end else if (byte_idx >= HDR_BYTES && audio_q) begin
                        rx_fifo_wr_o <= 1'b1;
                    end
                end
            end
        end
    end

    // audio byte lines up with the write strobe
    always_ff @(posedge rx_clock) begin
        if (udp_rx_i.active) begin
            rx_fifo_data_o <= udp_rx_i.data;
        end
    end

endmodule

`default_nettype wire

/* tx_packet_builder.sv */
`timescale 1ns/1ps
`default_nettype none

module tx_packet_builder
    import eth_proto_pkg::*, eth_link_pkg::*;
(
    input  logic        tx_clock,
    input  logic        arst_n_i,
    input  logic        network_ready_i,
    input  logic [47:0] local_mac_i,
    input  logic        udp_tx_grant_i,
    output udp_tx_t     udp_tx_o,
    input  run_ctrl_t   ctrl_i,
    input  logic        disc_toggle_i,
    input  logic        board_sel_i,
    input  logic [7:0]  assign_nr_i,
    input  logic [7:0]  iq_rdata_i,
    input  logic [10:0] iq_rdused_i,
    output logic        iq_rdreq_o,
    input  logic [7:0]  sp_rdata_i,
    input  logic        sp_ready_i,
    output logic        sp_rdreq_o
);

    typedef enum logic [1:0] {ST_IDLE, ST_REQUEST, ST_STREAM} state_t;
    typedef enum logic [1:0] {SRC_DISC, SRC_IQ, SRC_SP} src_t;

    state_t      state_q;
    src_t        src_q;
    logic [10:0] length_q;
    logic [10:0] offset_q;
    logic        toggle_q;
    logic        disc_edge;
    logic        disc_pend_q;
    logic [31:0] iq_seq_q;
    logic [31:0] sp_seq_q;
    logic [31:0] seq_cur;
    logic [7:0]  payload_byte;
    logic [7:0]  disc_byte;
    logic [7:0]  frame_byte;
    logic        payload_phase;

    assign disc_edge = disc_toggle_i ^ toggle_q;

    always_ff @(posedge tx_clock or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q     <= ST_IDLE;
            src_q       <= SRC_DISC;
            length_q    <= '0;
            offset_q    <= '0;
            toggle_q    <= 1'b0;
            disc_pend_q <= 1'b0;
            iq_seq_q    <= '0;
            sp_seq_q    <= '0;
        end else begin
            toggle_q <= disc_toggle_i;
            case (state_q)
                ST_IDLE: begin
                    offset_q <= '0;
                    // priority is discovery, then iq, then spectrum
                    if (network_ready_i) begin
                        if (disc_pend_q) begin
                            src_q       <= SRC_DISC;
                            length_q    <= DISC_BYTES;
                            state_q     <= ST_REQUEST;
                            disc_pend_q <= 1'b0;
                        end else if (ctrl_i.run && iq_rdused_i >= IQ_THRESHOLD) begin
                            src_q    <= SRC_IQ;
                            length_q <= FRAME_BYTES;
                            state_q  <= ST_REQUEST;
                        end else if (ctrl_i.wide_spectrum && sp_ready_i) begin
                            src_q    <= SRC_SP;
                            length_q <= FRAME_BYTES;
                            state_q  <= ST_REQUEST;
                        end
                    end
                end
                ST_REQUEST: begin
                    if (udp_tx_grant_i) begin
                        state_q <= ST_STREAM;
                    end
                end
                ST_STREAM: begin
                    if (offset_q == length_q - 11'd1) begin
                        state_q <= ST_IDLE;
                        if (src_q == SRC_IQ) begin
                            iq_seq_q <= iq_seq_q + 32'd1;
                        end else if (src_q == SRC_SP) begin
                            sp_seq_q <= sp_seq_q + 32'd1;
                        end
                    end else begin
                        offset_q <= offset_q + 11'd1;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
            // a new request wins over the clear above
            if (disc_edge) begin
                disc_pend_q <= 1'b1;
            end
        end
    end

    assign seq_cur      = (src_q == SRC_IQ) ? iq_seq_q : sp_seq_q;
    assign payload_byte = (src_q == SRC_IQ) ? iq_rdata_i : sp_rdata_i;

    always_comb begin
        disc_byte = 8'h00;
        case (offset_q)
            11'd0:        disc_byte = SYNC_BYTE0;
            11'd1:        disc_byte = SYNC_BYTE1;
            OFS_CMD:      disc_byte = ctrl_i.run ? DISC_REPLY_RUN : CMD_DISCOVER;
            DISC_VER_OFS: disc_byte = CODE_VERSION;
            DISC_ID_OFS:  disc_byte = board_sel_i ? BOARD_ID_B : BOARD_ID_A;
            DISC_NR_OFS:  disc_byte = assign_nr_i;
            default: begin
                // mac goes out msb first
                if (offset_q >= DISC_MAC_OFS && offset_q < DISC_VER_OFS) begin
                    disc_byte = local_mac_i[8 * (DISC_VER_OFS - 11'd1 - offset_q) +: 8];
                end
            end
        endcase
    end

    always_comb begin
        frame_byte = payload_byte;
        case (offset_q)
            11'd0:           frame_byte = SYNC_BYTE0;
            11'd1:           frame_byte = SYNC_BYTE1;
            OFS_CMD:         frame_byte = CMD_DATA;
            OFS_EP:          frame_byte = (src_q == SRC_IQ) ? EP_TX_IQ : EP_SPECTRUM;
            OFS_SEQ:         frame_byte = seq_cur[31:24];
            OFS_SEQ + 11'd1: frame_byte = seq_cur[23:16];
            OFS_SEQ + 11'd2: frame_byte = seq_cur[15:8];
            OFS_SEQ + 11'd3: frame_byte = seq_cur[7:0];
            default:         frame_byte = payload_byte;
        endcase
    end

    // show-ahead fifos, so the strobe pops the byte being sent
    assign payload_phase = (state_q == ST_STREAM) && (offset_q >= HDR_BYTES);
    assign iq_rdreq_o    = payload_phase && (src_q == SRC_IQ);
    assign sp_rdreq_o    = payload_phase && (src_q == SRC_SP);

    always_comb begin
        udp_tx_o.request = (state_q == ST_REQUEST);
        udp_tx_o.length  = length_q;
        udp_tx_o.active  = (state_q == ST_STREAM);
        udp_tx_o.data    = (src_q == SRC_DISC) ? disc_byte : frame_byte;
    end

endmodule

`default_nettype wire

/* hl_ethernet.sv */
`timescale 1ns/1ps
`default_nettype none

module hl_ethernet
    import eth_link_pkg::*;
(
    input  logic        tx_clock,
    input  logic        rx_clock,
    input  logic        arst_n_i,

    // udp side of the network stack
    input  udp_rx_t     udp_rx_i,
    input  logic        udp_tx_grant_i,
    output udp_tx_t     udp_tx_o,
    input  logic        network_ready_i,
    input  logic [47:0] local_mac_i,

    // board identity
    input  logic        board_sel_i,
    input  logic [7:0]  assign_nr_i,

    // transmit sample fifo
    input  logic [7:0]  iq_rdata_i,
    input  logic [10:0] iq_rdused_i,
    output logic        iq_rdreq_o,

    // spectrum fifo
    input  logic [7:0]  sp_rdata_i,
    input  logic        sp_ready_i,
    output logic        sp_rdreq_o,

    // receive audio fifo
    output logic        rx_fifo_wr_o,
    output logic [7:0]  rx_fifo_data_o,

    output logic        run_o
);

    // rx_clock side
    run_ctrl_t ctrl_rx;
    logic      disc_toggle_rx;

    // tx_clock side
    run_ctrl_t ctrl_tx;
    logic      disc_toggle_tx;

    rx_command_decoder rx_decoder_inst (
        .rx_clock      (rx_clock),
        .arst_n_i      (arst_n_i),
        .udp_rx_i      (udp_rx_i),
        .ctrl_o        (ctrl_rx),
        .disc_toggle_o (disc_toggle_rx),
        .rx_fifo_wr_o  (rx_fifo_wr_o),
        .rx_fifo_data_o(rx_fifo_data_o)
    );

    cdc_sync #(.sync_t(run_ctrl_t)) ctrl_sync_inst (
        .clock   (tx_clock),
        .arst_n_i(arst_n_i),
        .d_i     (ctrl_rx),
        .q_o     (ctrl_tx)
    );

    // discovery crosses as a toggle so no request is lost
    cdc_sync #(.sync_t(logic)) disc_sync_inst (
        .clock   (tx_clock),
        .arst_n_i(arst_n_i),
        .d_i     (disc_toggle_rx),
        .q_o     (disc_toggle_tx)
    );

    tx_packet_builder tx_builder_inst (
        .tx_clock       (tx_clock),
        .arst_n_i       (arst_n_i),
        .network_ready_i(network_ready_i),
        .local_mac_i    (local_mac_i),
        .udp_tx_grant_i (udp_tx_grant_i),
        .udp_tx_o       (udp_tx_o),
        .ctrl_i         (ctrl_tx),
        .disc_toggle_i  (disc_toggle_tx),
        .board_sel_i    (board_sel_i),
        .assign_nr_i    (assign_nr_i),
        .iq_rdata_i     (iq_rdata_i),
        .iq_rdused_i    (iq_rdused_i),
        .iq_rdreq_o     (iq_rdreq_o),
        .sp_rdata_i     (sp_rdata_i),
        .sp_ready_i     (sp_ready_i),
        .sp_rdreq_o     (sp_rdreq_o)
    );

    assign run_o = ctrl_tx.run;

endmodule

`default_nettype wire

/* tb_hl_ethernet.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_hl_ethernet
    import eth_proto_pkg::*, eth_link_pkg::*;
();

    logic        tx_clock;
    logic        rx_clock;
    logic        arst_n;
    udp_rx_t     udp_rx;
    logic        udp_tx_grant;
    udp_tx_t     udp_tx;
    logic        network_ready;
    logic [47:0] local_mac;
    logic        board_sel;
    logic [7:0]  assign_nr;
    logic [7:0]  iq_rdata;
    logic [10:0] iq_rdused;
    logic        iq_rdreq;
    logic [7:0]  sp_rdata;
    logic        sp_ready;
    logic        sp_rdreq;
    logic        rx_fifo_wr;
    logic [7:0]  rx_fifo_data;
    logic        run_out;

    // fifo models and expected values
    logic [7:0]  iq_fifo[$];
    logic [7:0]  sp_fifo[$];
    logic [7:0]  rx_exp[$];
    int          tx_kinds[$];
    int          iq_fill_n;
    int          sp_fill_n;

    // network stack model states 0 idle 1 waiting 2 grant cycle 3 streaming
    int          net_st;
    int          cur_kind;
    int          wait_cnt;
    int          ofs;
    logic [10:0] req_len;
    logic        grant_nxt;
    logic        prev_ready;
    logic [31:0] iq_seq;
    logic [31:0] sp_seq;
    logic        run_state;
    logic [31:0] lfsr;
    logic [7:0]  fill_byte;
    logic [7:0]  exp_byte;
    logic [7:0]  exp_rx;
    logic [7:0]  rnd;
    logic        exp_bit;
    int          fd;

    hl_ethernet dut (
        .tx_clock       (tx_clock),
        .rx_clock       (rx_clock),
        .arst_n_i       (arst_n),
        .udp_rx_i       (udp_rx),
        .udp_tx_grant_i (udp_tx_grant),
        .udp_tx_o       (udp_tx),
        .network_ready_i(network_ready),
        .local_mac_i    (local_mac),
        .board_sel_i    (board_sel),
        .assign_nr_i    (assign_nr),
        .iq_rdata_i     (iq_rdata),
        .iq_rdused_i    (iq_rdused),
        .iq_rdreq_o     (iq_rdreq),
        .sp_rdata_i     (sp_rdata),
        .sp_ready_i     (sp_ready),
        .sp_rdreq_o     (sp_rdreq),
        .rx_fifo_wr_o   (rx_fifo_wr),
        .rx_fifo_data_o (rx_fifo_data),
        .run_o          (run_out)
    );

    always #2 tx_clock = ~tx_clock;

    // rx clock lags tx by 1 ns
    always begin
        #1;
        forever #2 rx_clock = ~rx_clock;
    end

    task automatic stop_run();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic flag_mismatch(input string name, input logic [47:0] exp,
                                 input logic [47:0] got);
        $display("FAIL t=%0t %s expected %h got %h", $time, name, exp, got);
        stop_run();
    endtask

    task automatic abort_with(input string what);
        $display("ERROR t=%0t %s", $time, what);
        stop_run();
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    task automatic rand_bits(input int n, output logic [7:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[6:0], lfsr[0]};
        end
    endtask

    function automatic logic [7:0] disc_byte_at(input int k);
        disc_byte_at = 8'h00;
        if (k == 0) begin
            disc_byte_at = SYNC_BYTE0;
        end else if (k == 1) begin
            disc_byte_at = SYNC_BYTE1;
        end else if (k == 2) begin
            disc_byte_at = run_state ? 8'h03 : 8'h02;
        end else if (k >= 3 && k <= 8) begin
            disc_byte_at = local_mac[8 * (8 - k) +: 8];
        end else if (k == 9) begin
            disc_byte_at = CODE_VERSION;
        end else if (k == 10) begin
            disc_byte_at = board_sel ? BOARD_ID_B : BOARD_ID_A;
        end else if (k == 11) begin
            disc_byte_at = assign_nr;
        end
    endfunction

    function automatic logic [7:0] frame_hdr_byte(input int k, input logic [7:0] ep,
                                                  input logic [31:0] seq);
        case (k)
            0:       frame_hdr_byte = SYNC_BYTE0;
            1:       frame_hdr_byte = SYNC_BYTE1;
            2:       frame_hdr_byte = CMD_DATA;
            3:       frame_hdr_byte = ep;
            default: frame_hdr_byte = seq[8 * (7 - k) +: 8];
        endcase
    endfunction

    // fifo models and network stack sampled mid-cycle
    always begin
        @(negedge tx_clock);
        grant_nxt = 1'b0;
        while (iq_fill_n > 0) begin
            rand_bits(8, fill_byte);
            iq_fifo.push_back(fill_byte);
            iq_fill_n--;
        end
        while (sp_fill_n > 0) begin
            rand_bits(8, fill_byte);
            sp_fifo.push_back(fill_byte);
            sp_fill_n--;
        end
        if (net_st != 3) begin
            assert (!udp_tx.active && !iq_rdreq && !sp_rdreq)
                else abort_with("active or fifo read outside a granted packet");
        end
        if (net_st == 0 && udp_tx.request) begin
            assert (prev_ready) else abort_with("request raised while network not ready");
            assert (tx_kinds.size() > 0) else abort_with("udp request with no packet expected");
            cur_kind = tx_kinds.pop_front();
            req_len  = (cur_kind == 0) ? DISC_BYTES : FRAME_BYTES;
            rand_bits(3, rnd);
            wait_cnt = rnd;
            net_st   = 1;
        end
        if (net_st == 1) begin
            assert (udp_tx.request) else abort_with("request dropped before grant");
            assert (udp_tx.length == req_len)
                else flag_mismatch("udp_tx_o.length", req_len, udp_tx.length);
            if (wait_cnt == 0) begin
                grant_nxt = 1'b1;
                net_st    = 2;
            end else begin
                wait_cnt--;
            end
        end else if (net_st == 2) begin
            assert (udp_tx.request) else abort_with("request dropped in the grant cycle");
            net_st = 3;
            ofs    = 0;
        end else if (net_st == 3) begin
            assert (udp_tx.active && !udp_tx.request)
                else abort_with("active low or request high inside a packet");
            exp_bit = (cur_kind == 1) && (ofs >= HDR_BYTES);
            assert (iq_rdreq == exp_bit) else flag_mismatch("iq_rdreq_o", exp_bit, iq_rdreq);
            exp_bit = (cur_kind == 2) && (ofs >= HDR_BYTES);
            assert (sp_rdreq == exp_bit) else flag_mismatch("sp_rdreq_o", exp_bit, sp_rdreq);
            if (cur_kind == 0) begin
                exp_byte = disc_byte_at(ofs);
            end else if (ofs < HDR_BYTES && cur_kind == 1) begin
                exp_byte = frame_hdr_byte(ofs, EP_TX_IQ, iq_seq);
            end else if (ofs < HDR_BYTES) begin
                exp_byte = frame_hdr_byte(ofs, EP_SPECTRUM, sp_seq);
            end else if (cur_kind == 1) begin
                exp_byte = iq_fifo.pop_front();
            end else begin
                exp_byte = sp_fifo.pop_front();
            end
            assert (udp_tx.data == exp_byte)
                else flag_mismatch("udp_tx_o.data", exp_byte, udp_tx.data);
            ofs++;
            if (ofs == req_len) begin
                net_st = 0;
                if (cur_kind == 1) begin
                    iq_seq++;
                end else if (cur_kind == 2) begin
                    sp_seq++;
                end
            end
        end
        prev_ready = network_ready;
        @(posedge tx_clock);
        #0.5;
        udp_tx_grant = grant_nxt;
        iq_rdata     = (iq_fifo.size() > 0) ? iq_fifo[0] : 8'h00;
        iq_rdused    = iq_fifo.size();
        sp_rdata     = (sp_fifo.size() > 0) ? sp_fifo[0] : 8'h00;
        sp_ready     = (sp_fifo.size() >= PAYLOAD_BYTES);
    end

    // rx fifo write port
    always @(negedge rx_clock) begin
        if (rx_fifo_wr) begin
            assert (rx_exp.size() > 0) else abort_with("unexpected rx fifo write");
            exp_rx = rx_exp.pop_front();
            assert (rx_fifo_data == exp_rx)
                else flag_mismatch("rx_fifo_data_o", exp_rx, rx_fifo_data);
        end
    end

    task automatic tx_step();
        @(posedge tx_clock);
        #0.5;
    endtask

    task automatic read_field(output logic [47:0] v);
        int r;
        r = $fscanf(fd, "%h", v);
        assert (r == 1) else abort_with("malformed record in hl_ethernet_tests.txt");
    endtask

    task automatic send_packet();
        logic [47:0] port;
        logic [47:0] bcast;
        logic [47:0] len;
        logic [47:0] b;
        logic [7:0]  pkt [0:63];
        read_field(port);
        read_field(bcast);
        read_field(len);
        assert (len <= 64) else abort_with("rx packet record too long");
        for (int i = 0; i < len; i++) begin
            read_field(b);
            pkt[i] = b[7:0];
        end
        for (int i = 0; i < len; i++) begin
            @(posedge rx_clock);
            #0.5;
            udp_rx.active    = 1'b1;
            udp_rx.data      = pkt[i];
            udp_rx.to_port   = port[15:0];
            udp_rx.broadcast = bcast[0];
        end
        @(posedge rx_clock);
        #0.5;
        udp_rx = '0;
        repeat (2) @(posedge rx_clock);
    endtask

    task automatic wait_run(input logic v);
        int cnt;
        cnt = 0;
        @(negedge tx_clock);
        while (run_out !== v) begin
            @(negedge tx_clock);
            cnt++;
            assert (cnt < 64) else abort_with("timeout waiting for run_o");
        end
        tx_step();
        run_state = v;
    endtask

    task automatic wait_drained();
        int cnt;
        cnt = 0;
        @(posedge tx_clock);
        while (tx_kinds.size() != 0 || net_st != 0 || rx_exp.size() != 0) begin
            @(posedge tx_clock);
            cnt++;
            assert (cnt < 2000) else abort_with("timeout waiting for expected packets");
        end
    endtask

    task automatic run_record(input logic [47:0] code);
        logic [47:0] a;
        logic [47:0] b;
        logic [47:0] c;
        case (code)
            48'h01: send_packet();
            48'h02, 48'h03: begin
                read_field(a);
                tx_step();
                if (code == 48'h02) begin
                    iq_fill_n += a;
                end else begin
                    sp_fill_n += a;
                end
            end
            48'h04, 48'h05: begin
                read_field(a);
                tx_step();
                for (int i = 0; i < a; i++) begin
                    read_field(b);
                    if (code == 48'h04) begin
                        rx_exp.push_back(b[7:0]);
                    end else begin
                        tx_kinds.push_back(b);
                    end
                end
            end
            48'h06: begin
                read_field(a);
                wait_run(a[0]);
            end
            48'h07: begin
                read_field(a);
                tx_step();
                network_ready = a[0];
            end
            48'h08: begin
                read_field(a);
                repeat (a) tx_step();
            end
            48'h09: begin
                read_field(a);
                read_field(b);
                read_field(c);
                tx_step();
                local_mac = a;
                board_sel = b[0];
                assign_nr = c[7:0];
            end
            48'h0a: wait_drained();
            default: abort_with("unknown record code in hl_ethernet_tests.txt");
        endcase
    endtask

    initial begin
        logic [8*16-1:0]  tok;
        logic [8*200-1:0] line;
        logic [47:0]      code;
        int               r;
        tx_clock      = 1'b0;
        rx_clock      = 1'b0;
        arst_n        = 1'b0;
        udp_rx        = '0;
        udp_tx_grant  = 1'b0;
        network_ready = 1'b0;
        local_mac     = '0;
        board_sel     = 1'b0;
        assign_nr     = '0;
        iq_rdata      = '0;
        iq_rdused     = '0;
        sp_rdata      = '0;
        sp_ready      = 1'b0;
        iq_fill_n     = 0;
        sp_fill_n     = 0;
        net_st        = 0;
        prev_ready    = 1'b0;
        iq_seq        = '0;
        sp_seq        = '0;
        run_state     = 1'b0;
        lfsr          = 32'h18e6;
        repeat (5) @(posedge tx_clock);
        #0.5;
        arst_n = 1'b1;
        @(negedge tx_clock);
        assert (!udp_tx.request && !udp_tx.active && !iq_rdreq && !sp_rdreq &&
                !rx_fifo_wr && !run_out)
            else abort_with("control outputs not inactive after reset");
        fd = $fopen("hl_ethernet_tests.txt", "r");
        assert (fd != 0) else abort_with("cannot open hl_ethernet_tests.txt");
        while ($fscanf(fd, "%s", tok) == 1) begin
            if (tok == "#") begin
                r = $fgets(line, fd);
            end else begin
                r = $sscanf(tok, "%h", code);
                assert (r == 1) else abort_with("malformed record code in hl_ethernet_tests.txt");
                run_record(code);
            end
        end
        $fclose(fd);
        wait_drained();
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
eth_proto_pkg.sv
eth_link_pkg.sv
cdc_sync.sv
rx_command_decoder.sv
tx_packet_builder.sv
hl_ethernet.sv
tb_hl_ethernet.sv

/* hl_ethernet_tests.txt */
# one record per line, all fields hex, first field is the record code
# 01 port bcast len bytes..  send rx packet | 02 n fill iq fifo | 03 n fill spectrum fifo
# 04 n words..  expected rx fifo writes | 05 n kinds..  expected tx packets (0 disc 1 iq 2 sp)
# 06 v  wait for run_o | 07 v  network ready | 08 n  idle cycles
# 09 mac board_sel assign_nr  identity | 0a  wait until all expectations are met
09 0a1b2c3d4e5f 1 07
07 1
# reset and idle
08 14
# discovery reply, then discovery packets that must be ignored
05 1 0
01 0400 1 4 ef fe 02 00
0a
01 0400 0 4 ef fe 02 00
01 0401 1 4 ef fe 02 00
08 20
# run and iq frames
01 0400 0 4 ef fe 04 01
06 1
05 2 1 1
02 40
0a
# spectrum and priority, both sources become eligible together
01 0400 0 4 ef fe 04 00
06 0
02 20
03 20
08 10
05 2 1 2
01 0400 0 4 ef fe 04 03
06 1
0a
# rx audio forwarding, then bad sync packets
04 6 11 22 33 44 55 66
01 0400 0 e ef fe 01 02 00 00 00 07 11 22 33 44 55 66
0a
01 0400 0 4 ef ff 04 00
01 0400 0 a ef 00 01 02 00 00 00 08 aa bb
08 20
06 1
# network not ready, then late grants
07 0
02 20
08 20
05 1 1
07 1
0a
09 0a1b2c3d4e5f 0 2a
05 1 0
01 0400 1 4 ef fe 02 00
0a
